// File: lc4_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc4_settings.svh"

module lc4_alu import lc4_pkg::*; (
  input  alu_op_t i_alu_op,
  input  logic    i_is_branch,
  input  word_t   i_pc,        // PC of the executing instruction
  input  word_t   i_a,         // First operand, bypassed
  input  word_t   i_b,         // Second operand, zero unless a register form
  input  word_t   i_imm,       // Zero for register forms
  output word_t   o_result
);

  word_t opnd;
  word_t sum;
  word_t diff;

  // Only one side is ever nonzero, so OR merges register and immediate
  assign opnd = i_b | i_imm;

  assign sum  = i_a + opnd;    // ADD, ADD-imm and LDR/STR address
  assign diff = i_a - opnd;

  always_comb begin
    if (i_is_branch) begin
      o_result = i_pc + 16'd1 + i_imm;     // Branch target
    end else begin
      case (i_alu_op)
        `LC4_ALU_ADD: begin
          o_result = sum;
        end
        `LC4_ALU_SUB: begin
          o_result = diff;
        end
        `LC4_ALU_AND: begin
          o_result = i_a & opnd;
        end
        `LC4_ALU_OR: begin
          o_result = i_a | opnd;
        end
        `LC4_ALU_CONST: begin
          o_result = i_imm;                // Already sign extended
        end
        `LC4_ALU_HICONST: begin
          o_result = {i_imm[7:0], i_a[7:0]};  // New high byte over old low byte
        end
        default: begin
          o_result = sum;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: lc4_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc4_settings.svh"

module lc4_decoder import lc4_pkg::*; (
  input  word_t    i_insn,
  output reg_idx_t o_rs,
  output reg_idx_t o_rt,
  output reg_idx_t o_rd,
  output logic     o_rs_re,       // First source read
  output logic     o_rt_re,       // Second source read, also store data
  output logic     o_regfile_we,
  output logic     o_nzp_we,
  output logic     o_is_load,
  output logic     o_is_store,
  output logic     o_is_branch,
  output alu_op_t  o_alu_op,
  output word_t    o_imm          // Zero for register forms
);

  opcode_t    opcode;
  logic [2:0] sub_op;
  word_t      sext5;
  word_t      sext6;
  word_t      sext9;
  word_t      zext8;

  assign opcode = i_insn[15:12];
  assign sub_op = i_insn[5:3];

  // Immediate extensions
  assign sext5 = {{11{i_insn[4]}}, i_insn[4:0]};
  assign sext6 = {{10{i_insn[5]}}, i_insn[5:0]};
  assign sext9 = {{7{i_insn[8]}}, i_insn[8:0]};
  assign zext8 = {8'h00, i_insn[7:0]};     // HICONST byte

  always_comb begin
    // Defaults give a NOP
    o_rs         = i_insn[8:6];
    o_rt         = i_insn[2:0];
    o_rd         = i_insn[11:9];
    o_rs_re      = 1'b0;
    o_rt_re      = 1'b0;
    o_regfile_we = 1'b0;
    o_is_load    = 1'b0;
    o_is_store   = 1'b0;
    o_is_branch  = 1'b0;
    o_alu_op     = `LC4_ALU_ADD;
    o_imm        = '0;
    case (opcode)
      `LC4_OP_BR: begin
        o_is_branch = 1'b1;                // nzp 000 never fires
        o_imm       = sext9;
      end
      `LC4_OP_ARITH: begin
        if (i_insn[5]) begin               // ADD immediate
          o_rs_re      = 1'b1;
          o_regfile_we = 1'b1;
          o_imm        = sext5;
        end else if (sub_op == `LC4_SUB_ADD || sub_op == `LC4_SUB_SUB) begin
          o_rs_re      = 1'b1;
          o_rt_re      = 1'b1;
          o_regfile_we = 1'b1;
          o_alu_op     = (sub_op == `LC4_SUB_SUB) ? `LC4_ALU_SUB : `LC4_ALU_ADD;
        end
      end
      `LC4_OP_LOGIC: begin
        if (sub_op == `LC4_SUB_AND || sub_op == `LC4_SUB_OR) begin
          o_rs_re      = 1'b1;
          o_rt_re      = 1'b1;
          o_regfile_we = 1'b1;
          o_alu_op     = (sub_op == `LC4_SUB_OR) ? `LC4_ALU_OR : `LC4_ALU_AND;
        end
      end
      `LC4_OP_LDR: begin
        o_rs_re      = 1'b1;               // Base register
        o_regfile_we = 1'b1;
        o_is_load    = 1'b1;
        o_imm        = sext6;
      end
      `LC4_OP_STR: begin
        o_rs_re    = 1'b1;
        o_rt       = i_insn[11:9];         // Data register sits in the rd field
        o_rt_re    = 1'b1;
        o_is_store = 1'b1;
        o_imm      = sext6;
      end
      `LC4_OP_CONST: begin
        o_regfile_we = 1'b1;
        o_alu_op     = `LC4_ALU_CONST;
        o_imm        = sext9;
      end
      `LC4_OP_HICONST: begin
        o_rs         = i_insn[11:9];       // Old low byte comes from rd
        o_rs_re      = 1'b1;
        o_regfile_we = 1'b1;
        o_alu_op     = `LC4_ALU_HICONST;
        o_imm        = zext8;
      end
      default: begin
      end
    endcase
  end

  // Every register write also sets the condition codes
  assign o_nzp_we = o_regfile_we;

  // No decoded opcode both stores and writes a register
  always_comb begin
    if (!$isunknown(i_insn)) begin
      assert (!(o_is_store && o_regfile_we))
        else $error("lc4_decoder: store with register write, insn %h", i_insn);
    end
  end

endmodule

`default_nettype wire

// File: lc4_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_hazard_unit import lc4_pkg::*; (
  // Decode
  input  reg_idx_t   i_d_rs,
  input  reg_idx_t   i_d_rt,
  input  logic       i_d_rs_re,
  input  logic       i_d_rt_re,
  // Execute
  input  reg_idx_t   i_x_rs,
  input  reg_idx_t   i_x_rt,
  input  reg_idx_t   i_x_rd,
  input  logic       i_x_is_load,
  input  logic       i_x_is_branch,
  input  nzp_t       i_x_branch_nzp,  // Condition bits of the branch
  // Memory
  input  reg_idx_t   i_m_rd,
  input  logic       i_m_regfile_we,
  input  logic       i_m_nzp_we,
  input  nzp_t       i_m_nzp,
  // Writeback
  input  reg_idx_t   i_w_rd,
  input  logic       i_w_regfile_we,
  input  logic       i_w_nzp_we,
  input  nzp_t       i_w_nzp,
  input  nzp_t       i_nzp_reg,       // Architectural condition codes
  output logic       o_stall,
  output logic       o_flush,
  output logic [1:0] o_a_sel,         // 00 register, 01 memory, 10 writeback
  output logic [1:0] o_b_sel,
  output nzp_t       o_nzp            // Newest condition codes seen by execute
);

  logic rs_hit;
  logic rt_hit;

  // Memory stage is younger than writeback, so it wins
  function automatic logic [1:0] src_sel(input reg_idx_t src);
    if (i_m_regfile_we && i_m_rd == src) begin
      return 2'b01;
    end else if (i_w_regfile_we && i_w_rd == src) begin
      return 2'b10;
    end
    return 2'b00;
  endfunction

  assign o_a_sel = src_sel(i_x_rs);
  assign o_b_sel = src_sel(i_x_rt);

  // Same ordering for condition codes
  assign o_nzp = i_m_nzp_we ? i_m_nzp : (i_w_nzp_we ? i_w_nzp : i_nzp_reg);

  // Load in execute feeding decode, store data included
  assign rs_hit = i_d_rs_re && (i_d_rs == i_x_rd);
  assign rt_hit = i_d_rt_re && (i_d_rt == i_x_rd);

  always_comb begin
    o_stall = i_x_is_load && (rs_hit || rt_hit);
    o_flush = i_x_is_branch && |(i_x_branch_nzp & o_nzp);   // Taken branch
    // A load never resolves a branch, so holding and squashing exclude each other
    if (!$isunknown({o_stall, o_flush})) begin
      assert (!(o_stall && o_flush))
        else $error("lc4_hazard_unit: stall and flush together");
    end
  end

endmodule

`default_nettype wire

// File: lc4_pkg.sv
`default_nettype none

// Types shared by the pipeline and its testbench
package lc4_pkg;

  // Machine word: PC, instruction and data
  typedef logic [15:0] word_t;

  // Register number, R0..R7
  typedef logic [2:0] reg_idx_t;

  // Condition codes, bit 2 negative, bit 1 zero, bit 0 positive
  typedef logic [2:0] nzp_t;

  // Top field of an instruction
  typedef logic [3:0] opcode_t;

  // ALU operation select, see LC4_ALU_* codes
  typedef logic [2:0] alu_op_t;

endpackage

`default_nettype wire

// File: lc4_processor.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc4_settings.svh"

module lc4_processor import lc4_pkg::*; (
  input  logic     gwe,
  input  logic     i_reset,
  output word_t    o_imem_addr,
  input  word_t    i_imem_insn,     // Same-cycle instruction
  output word_t    o_dmem_addr,     // Zero unless LDR/STR in memory stage
  input  word_t    i_dmem_rdata,    // Same-cycle load data
  output logic     o_dmem_we,
  output word_t    o_dmem_wdata,
  output logic     o_wb_we,         // Retiring register write
  output reg_idx_t o_wb_sel,
  output word_t    o_wb_data
);

  word_t      pc, next_pc;
  // Decode stage
  word_t      d_pc, d_insn, d_imm, d_rs_data, d_rt_data;
  reg_idx_t   d_rs, d_rt, d_rd;
  logic       d_rs_re, d_rt_re, d_regfile_we, d_nzp_we, d_is_load, d_is_store, d_is_branch;
  alu_op_t    d_alu_op;
  // Execute stage
  word_t      x_pc, x_imm, x_rs_data, x_rt_data, x_a, x_b, x_alu_b, x_result;
  reg_idx_t   x_rs, x_rt, x_rd;
  logic       x_rt_re, x_regfile_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;
  nzp_t       x_branch_nzp;
  alu_op_t    x_alu_op;
  // Memory stage
  word_t      m_alu_result, m_store_data, m_result;
  reg_idx_t   m_rd;
  logic       m_regfile_we, m_nzp_we, m_is_load, m_is_store;
  nzp_t       m_nzp;
  // Writeback stage
  word_t      w_data;
  reg_idx_t   w_rd;
  logic       w_regfile_we, w_nzp_we;
  nzp_t       w_nzp, nzp_reg, nzp_fwd;
  // Hazard controls
  logic       stall, flush;
  logic [1:0] a_sel, b_sel;

  // Execute operand source
  function automatic word_t pick(input logic [1:0] sel, input word_t rf_val,
                                 input word_t m_val, input word_t w_val);
    case (sel)
      2'b01:   return m_val;
      2'b10:   return w_val;
      default: return rf_val;
    endcase
  endfunction

  // Fetch: hold on stall, redirect on taken branch
  assign next_pc     = stall ? pc : (flush ? x_result : pc + 16'd1);
  assign o_imem_addr = pc;

  always_ff @(posedge gwe) begin
    if (i_reset) begin
      pc <= `LC4_RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge gwe) begin
    if (i_reset || flush) begin
      d_insn <= `LC4_NOP_INSN;     // Squash the wrong-path fetch
    end else if (!stall) begin
      d_insn <= i_imem_insn;
    end
    if (!stall) begin
      d_pc <= pc;
    end
  end

  lc4_decoder u_lc4_decoder (
    .i_insn(d_insn), .o_rs(d_rs), .o_rt(d_rt), .o_rd(d_rd),
    .o_rs_re(d_rs_re), .o_rt_re(d_rt_re), .o_regfile_we(d_regfile_we),
    .o_nzp_we(d_nzp_we), .o_is_load(d_is_load), .o_is_store(d_is_store),
    .o_is_branch(d_is_branch), .o_alu_op(d_alu_op), .o_imm(d_imm)
  );

  lc4_regfile u_lc4_regfile (
    .gwe(gwe), .i_reset(i_reset), .i_rs(d_rs), .i_rt(d_rt), .i_rd(w_rd),
    .i_rd_we(w_regfile_we), .i_wdata(w_data),
    .o_rs_data(d_rs_data), .o_rt_data(d_rt_data)
  );

  // Decode to execute, bubble on stall or flush
  always_ff @(posedge gwe) begin
    if (i_reset || stall || flush) begin
      x_rs         <= '0;
      x_rt         <= '0;
      x_rd         <= '0;
      x_rt_re      <= 1'b0;
      x_regfile_we <= 1'b0;
      x_nzp_we     <= 1'b0;
      x_is_load    <= 1'b0;
      x_is_store   <= 1'b0;
      x_is_branch  <= 1'b0;
      x_branch_nzp <= '0;
      x_alu_op     <= `LC4_ALU_ADD;
    end else begin
      x_rs         <= d_rs;
      x_rt         <= d_rt;
      x_rd         <= d_rd;
      x_rt_re      <= d_rt_re;
      x_regfile_we <= d_regfile_we;
      x_nzp_we     <= d_nzp_we;
      x_is_load    <= d_is_load;
      x_is_store   <= d_is_store;
      x_is_branch  <= d_is_branch;
      x_branch_nzp <= d_insn[11:9];
      x_alu_op     <= d_alu_op;
    end
    x_pc      <= d_pc;
    x_imm     <= d_imm;
    x_rs_data <= d_rs_data;
    x_rt_data <= d_rt_data;
  end

  assign x_a = pick(a_sel, x_rs_data, m_result, w_data);
  assign x_b = pick(b_sel, x_rt_data, m_result, w_data);
  assign x_alu_b = (x_rt_re && !x_is_store) ? x_b : '0;   // Store data bypasses the ALU

  lc4_alu u_lc4_alu (
    .i_alu_op(x_alu_op), .i_is_branch(x_is_branch), .i_pc(x_pc),
    .i_a(x_a), .i_b(x_alu_b), .i_imm(x_imm), .o_result(x_result)
  );

  lc4_hazard_unit u_lc4_hazard_unit (
    .i_d_rs(d_rs), .i_d_rt(d_rt), .i_d_rs_re(d_rs_re), .i_d_rt_re(d_rt_re),
    .i_x_rs(x_rs), .i_x_rt(x_rt), .i_x_rd(x_rd), .i_x_is_load(x_is_load),
    .i_x_is_branch(x_is_branch), .i_x_branch_nzp(x_branch_nzp),
    .i_m_rd(m_rd), .i_m_regfile_we(m_regfile_we), .i_m_nzp_we(m_nzp_we), .i_m_nzp(m_nzp),
    .i_w_rd(w_rd), .i_w_regfile_we(w_regfile_we), .i_w_nzp_we(w_nzp_we), .i_w_nzp(w_nzp),
    .i_nzp_reg(nzp_reg), .o_stall(stall), .o_flush(flush),
    .o_a_sel(a_sel), .o_b_sel(b_sel), .o_nzp(nzp_fwd)
  );

  // Execute to memory
  always_ff @(posedge gwe) begin
    if (i_reset) begin
      m_rd         <= '0;
      m_regfile_we <= 1'b0;
      m_nzp_we     <= 1'b0;
      m_is_load    <= 1'b0;
      m_is_store   <= 1'b0;
    end else begin
      m_rd         <= x_rd;
      m_regfile_we <= x_regfile_we;
      m_nzp_we     <= x_nzp_we;
      m_is_load    <= x_is_load;
      m_is_store   <= x_is_store;
    end
    m_alu_result <= x_result;
    m_store_data <= x_b;
  end

  // Memory stage result and its condition codes, both bypassable
  assign m_result = m_is_load ? i_dmem_rdata : m_alu_result;
  assign m_nzp    = m_result[15] ? 3'b100 : ((m_result == '0) ? 3'b010 : 3'b001);

  assign o_dmem_addr  = (m_is_load || m_is_store) ? m_alu_result : '0;
  assign o_dmem_we    = m_is_store;
  assign o_dmem_wdata = m_store_data;

  // Memory to writeback, then condition code register
  always_ff @(posedge gwe) begin
    if (i_reset) begin
      w_rd         <= '0;
      w_regfile_we <= 1'b0;
      w_nzp_we     <= 1'b0;
      nzp_reg      <= '0;      // No branch taken before first write
    end else begin
      w_rd         <= m_rd;
      w_regfile_we <= m_regfile_we;
      w_nzp_we     <= m_nzp_we;
      if (w_nzp_we) begin
        nzp_reg <= w_nzp;
      end
    end
    w_data <= m_result;
    w_nzp  <= m_nzp;
  end

  assign o_wb_we   = w_regfile_we;
  assign o_wb_sel  = w_rd;
  assign o_wb_data = w_data;

endmodule

`default_nettype wire

// File: lc4_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile import lc4_pkg::*; (
  input  logic     gwe,
  input  logic     i_reset,
  input  reg_idx_t i_rs,
  input  reg_idx_t i_rt,
  input  reg_idx_t i_rd,        // Writeback destination
  input  logic     i_rd_we,
  input  word_t    i_wdata,
  output word_t    o_rs_data,
  output word_t    o_rt_data
);

  word_t regs [8];

  always_ff @(posedge gwe) begin
    if (i_reset) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_we) begin
      regs[i_rd] <= i_wdata;   // Lands at the edge ending writeback
    end
  end

  // Write-before-read, decode sees the value retiring this cycle
  assign o_rs_data = (i_rd_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
  assign o_rt_data = (i_rd_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

  // Writeback enable comes from reset pipeline state and must stay known
  assert property (@(posedge gwe) disable iff (i_reset) !$isunknown(i_rd_we))
    else $error("lc4_regfile: unknown write enable");

endmodule

`default_nettype wire

// File: lc4_settings.svh
`ifndef LC4_SETTINGS_SVH
`define LC4_SETTINGS_SVH

// First fetch address out of reset
`define LC4_RESET_PC    16'h8200

// Opcodes, insn[15:12]
`define LC4_OP_BR       4'b0000
`define LC4_OP_ARITH    4'b0001
`define LC4_OP_LOGIC    4'b0101
`define LC4_OP_LDR      4'b0110
`define LC4_OP_STR      4'b0111
`define LC4_OP_CONST    4'b1001
`define LC4_OP_HICONST  4'b1101

// Sub-opcodes, insn[5:3], bit 5 set means immediate form
`define LC4_SUB_ADD     3'b000
`define LC4_SUB_SUB     3'b010
`define LC4_SUB_AND     3'b000
`define LC4_SUB_OR      3'b010

// ALU operation select
`define LC4_ALU_ADD     3'd0
`define LC4_ALU_SUB     3'd1
`define LC4_ALU_AND     3'd2
`define LC4_ALU_OR      3'd3
`define LC4_ALU_CONST   3'd4
`define LC4_ALU_HICONST 3'd5

`define LC4_NOP_INSN    16'h0000  // BR with nzp 000, never taken

`endif

// File: run.sh
#!/bin/sh
# Build and run the LC4 pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --top-module tb_lc4_processor -f verilog.f -o tb_lc4_processor

# Simulator status is masked by tee, the log decides
./obj_dir/tb_lc4_processor 2>&1 | tee sim.log

if grep -q "all tests passed" sim.log; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1

// File: tb_lc4_processor.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc4_settings.svh"

module tb_lc4_processor import lc4_pkg::*; ();

  localparam int          WAIT_LIMIT = 50;             // Cycles allowed per expected pulse
  localparam logic [31:0] SEED       = 32'ha4b64620;

  logic     gwe;
  logic     reset;
  word_t    imem_addr, imem_insn, dmem_addr, dmem_rdata, dmem_wdata, wb_data;
  logic     dmem_we, wb_we;
  reg_idx_t wb_sel;

  word_t imem [65536];
  word_t dmem [65536];
  word_t ref_mem [65536];      // Untouched copy, predicts load data

  // Program and expectation tables
  word_t    prog [$];
  reg_idx_t exp_sel [$];
  word_t    exp_val [$];
  word_t    exp_addr [$];
  word_t    exp_data [$];
  int       wb_seen = 0;
  int       st_seen = 0;

  lc4_processor u_lc4_processor (
    .gwe(gwe), .i_reset(reset), .o_imem_addr(imem_addr), .i_imem_insn(imem_insn),
    .o_dmem_addr(dmem_addr), .i_dmem_rdata(dmem_rdata), .o_dmem_we(dmem_we),
    .o_dmem_wdata(dmem_wdata), .o_wb_we(wb_we), .o_wb_sel(wb_sel), .o_wb_data(wb_data)
  );

  initial begin
    gwe = 1'b0;
    forever #20 gwe = ~gwe;    // 40 ns period
  end

  // Both memories answer in the same cycle
  assign imem_insn  = imem[imem_addr];
  assign dmem_rdata = dmem[dmem_addr];

  always @(negedge gwe) begin
    if (dmem_we) begin
      dmem[dmem_addr] <= dmem_wdata;   // Store lands mid-cycle, next load sees it
    end
  end

  // Pulse counters for the totals check
  always @(negedge gwe) begin
    if (!reset) begin
      if (wb_we) begin
        wb_seen <= wb_seen + 1;
      end
      if (dmem_we) begin
        st_seen <= st_seen + 1;
      end
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Instruction encoders, straight from the LC4 formats
  function automatic word_t rrr_insn(input logic [3:0] op, input int rd, input int rs,
                                     input int sub, input int rt);
    return {op, rd[2:0], rs[2:0], sub[2:0], rt[2:0]};
  endfunction

  function automatic word_t addi_insn(input int rd, input int rs, input int imm);
    return {`LC4_OP_ARITH, rd[2:0], rs[2:0], 1'b1, imm[4:0]};
  endfunction

  function automatic word_t mem_insn(input logic [3:0] op, input int rd, input int rs,
                                     input int imm);
    return {op, rd[2:0], rs[2:0], imm[5:0]};   // rd is the data register for STR
  endfunction

  function automatic word_t const_insn(input int rd, input int imm);
    return {`LC4_OP_CONST, rd[2:0], imm[8:0]};
  endfunction

  function automatic word_t hiconst_insn(input int rd, input int imm);
    return {`LC4_OP_HICONST, rd[2:0], 1'b1, imm[7:0]};
  endfunction

  function automatic word_t br_insn(input int nzp, input int imm);
    return {`LC4_OP_BR, nzp[2:0], imm[8:0]};
  endfunction

  task automatic emit(input word_t insn);
    prog.push_back(insn);
  endtask

  task automatic expect_wb(input int rd, input word_t value);
    exp_sel.push_back(rd[2:0]);
    exp_val.push_back(value);
  endtask

  task automatic note_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      abort_run($sformatf("ERR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic fill_memories();
    logic [31:0] state;
    state = SEED;
    for (int a = 0; a < 65536; a++) begin
      state = next_random(state);
      dmem[word_t'(a)]    = state[15:0];
      ref_mem[word_t'(a)] = state[15:0];
      imem[word_t'(a)]    = `LC4_NOP_INSN;
    end
  endtask

  task automatic build_program();
    word_t l1;
    word_t l2;
    word_t dbl;
    l1  = ref_mem[16'h4013];
    l2  = ref_mem[16'h4014];
    dbl = l1 + l1;
    emit(const_insn(1, 171));                      expect_wb(1, 16'h00AB);
    emit(hiconst_insn(1, 8'h5C));                  expect_wb(1, 16'h5CAB);
    emit(const_insn(2, -100));                     expect_wb(2, 16'hFF9C);
    emit(rrr_insn(`LC4_OP_ARITH, 3, 1, 0, 2));     expect_wb(3, 16'h5C47);  // ADD
    emit(rrr_insn(`LC4_OP_ARITH, 4, 3, 2, 1));     expect_wb(4, 16'hFF9C);  // SUB, R1 via regfile
    emit(addi_insn(5, 4, -7));                     expect_wb(5, 16'hFF95);
    emit(rrr_insn(`LC4_OP_LOGIC, 6, 1, 0, 5));     expect_wb(6, 16'h5C81);  // AND
    emit(rrr_insn(`LC4_OP_LOGIC, 7, 6, 2, 2));     expect_wb(7, 16'hFF9D);  // OR
    // R1 consumed at distance one, two and three
    emit(addi_insn(1, 1, 1));                      expect_wb(1, 16'h5CAC);
    emit(addi_insn(2, 1, 2));                      expect_wb(2, 16'h5CAE);
    emit(addi_insn(3, 1, 3));                      expect_wb(3, 16'h5CAF);
    emit(addi_insn(4, 1, 4));                      expect_wb(4, 16'h5CB0);
    // Loads and stores around base 0x4010
    emit(const_insn(1, 16));                       expect_wb(1, 16'h0010);
    emit(hiconst_insn(1, 8'h40));                  expect_wb(1, 16'h4010);
    emit(mem_insn(`LC4_OP_LDR, 2, 1, 3));          expect_wb(2, l1);
    emit(rrr_insn(`LC4_OP_ARITH, 3, 2, 0, 2));     expect_wb(3, dbl);       // Load-use stall
    emit(mem_insn(`LC4_OP_STR, 3, 1, -2));         note_store(16'h400E, dbl);
    emit(mem_insn(`LC4_OP_LDR, 4, 1, -2));         expect_wb(4, dbl);
    emit(mem_insn(`LC4_OP_STR, 4, 1, 5));          note_store(16'h4015, dbl);  // Stall on data
    emit(mem_insn(`LC4_OP_LDR, 5, 1, 4));          expect_wb(5, l2);
    emit(rrr_insn(`LC4_OP_ARITH, 6, 5, 0, 4));     expect_wb(6, l2 + dbl);
    emit(mem_insn(`LC4_OP_LDR, 7, 1, 5));          expect_wb(7, dbl);
    // Branches, nzp 4 n, 2 z, 1 p
    emit(const_insn(1, 0));                        expect_wb(1, 16'h0000);
    emit(br_insn(5, 2));                           // Not taken, Z from memory stage
    emit(addi_insn(2, 1, 9));                      expect_wb(2, 16'h0009);
    emit(br_insn(1, 2));                           // Taken
    emit(const_insn(7, -1));                       // Skipped
    emit(const_insn(7, -2));                       // Skipped
    emit(const_insn(3, -5));                       expect_wb(3, 16'hFFFB);
    emit(`LC4_NOP_INSN);
    emit(br_insn(4, 1));                           // Taken, N from writeback
    emit(const_insn(7, -3));                       // Skipped
    emit(br_insn(3, 1));                           // Not taken, N from nzp register
    emit(const_insn(5, 100));                      expect_wb(5, 16'h0064);
    emit(br_insn(7, -1));                          // Branch to self
  endtask

  task automatic walk_writebacks();
    int cycles;
    foreach (exp_sel[i]) begin
      cycles = 0;
      do begin
        @(negedge gwe);
        cycles++;
        if (cycles > WAIT_LIMIT) begin
          abort_run($sformatf("writeback %0d did not appear within %0d cycles", i, WAIT_LIMIT));
        end
      end while (wb_we !== 1'b1);
      check_value($sformatf("writeback %0d register", i), {13'b0, exp_sel[i]}, {13'b0, wb_sel});
      check_value($sformatf("writeback %0d value", i), exp_val[i], wb_data);
    end
  endtask

  task automatic walk_stores();
    int cycles;
    foreach (exp_addr[i]) begin
      cycles = 0;
      do begin
        @(negedge gwe);
        cycles++;
        if (cycles > 4 * WAIT_LIMIT) begin
          abort_run($sformatf("store %0d did not appear in time", i));
        end
      end while (dmem_we !== 1'b1);
      check_value($sformatf("store %0d address", i), exp_addr[i], dmem_addr);
      check_value($sformatf("store %0d data", i), exp_data[i], dmem_wdata);
    end
  endtask

  initial begin
    reset = 1'b1;
    fill_memories();
    build_program();
    foreach (prog[i]) begin
      imem[word_t'(`LC4_RESET_PC + i)] = prog[i];
    end
    repeat (16) begin
      @(negedge gwe);
      check_value("reset wb_we", 16'h0000, {15'b0, wb_we});
      check_value("reset dmem_we", 16'h0000, {15'b0, dmem_we});
      check_value("reset fetch address", `LC4_RESET_PC, imem_addr);
    end
    reset = 1'b0;
    // First edge out of reset fetches the reset PC and steps past it
    @(negedge gwe);
    check_value("first edge wb_we", 16'h0000, {15'b0, wb_we});
    check_value("first edge dmem_we", 16'h0000, {15'b0, dmem_we});
    check_value("second fetch address", `LC4_RESET_PC + 16'd1, imem_addr);
    fork
      walk_writebacks();
      walk_stores();
    join
    // Branch-to-self spins with nothing retiring
    repeat (20) begin
      @(negedge gwe);
      check_value("idle wb_we", 16'h0000, {15'b0, wb_we});
      check_value("idle dmem_we", 16'h0000, {15'b0, dmem_we});
    end
    check_value("writeback count", word_t'(exp_sel.size()), word_t'(wb_seen));
    check_value("store count", word_t'(exp_addr.size()), word_t'(st_seen));
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
lc4_pkg.sv
lc4_decoder.sv
lc4_alu.sv
lc4_regfile.sv
lc4_hazard_unit.sv
lc4_processor.sv
tb_lc4_processor.sv
